//--- verilog/flight_types_pkg.sv
// Flight data package: field widths, control limits and stage payload structs
`default_nettype none

package flight_types_pkg;

	// Receiver sticks are unsigned, centered at mid scale
	localparam int STICK_W      = 8;
	localparam int STICK_CENTER = 128;
	// Euler angles, gyro rates and corrections
	localparam int ANGLE_W      = 16;
	// ESC rate range
	localparam int MOTOR_W      = 8;
	localparam int MOTOR_MAX    = 250;
	// Below this throttle the motors stay off
	localparam int ARM_THRESHOLD = 10;
	// Magnitude limit of one rate correction
	localparam int CORR_LIMIT   = 100;

	typedef logic [STICK_W-1:0]        stick_t;
	typedef logic signed [ANGLE_W-1:0] angle_t;
	typedef logic [MOTOR_W-1:0]        motor_t;

	// Raw sample from receiver and IMU
	typedef struct packed {
		stick_t throttle;
		stick_t roll_stick;
		stick_t pitch_stick;
		stick_t yaw_stick;
		angle_t roll_angle;
		angle_t pitch_angle;
		angle_t yaw_angle;
		angle_t roll_rate;
		angle_t pitch_rate;
		angle_t yaw_rate;
	} flight_sample_t;

	// Angle stage result, gyro rates ride along for the rate stage
	typedef struct packed {
		stick_t throttle;
		angle_t roll_target;
		angle_t pitch_target;
		angle_t yaw_target;
		angle_t roll_rate;
		angle_t pitch_rate;
		angle_t yaw_rate;
	} rate_target_t;

	// Rate stage result
	typedef struct packed {
		stick_t throttle;
		angle_t roll_corr;
		angle_t pitch_corr;
		angle_t yaw_corr;
	} correction_t;

	// Mixer result, one rate per ESC
	typedef struct packed {
		motor_t motor_1;
		motor_t motor_2;
		motor_t motor_3;
		motor_t motor_4;
	} motor_rates_t;

endpackage

`default_nettype wire

//--- verilog/credit_link_pkg.sv
// Credit link package: credit counter type and default receive buffer depth
`default_nettype none

package credit_link_pkg;

	// Counter width, depths up to 15 fit
	localparam int CREDIT_W = 4;

	// Credits held by a sender, also the item count of a buffer
	typedef logic [CREDIT_W-1:0] credit_t;

	// Stage buffers and output credits unless the top level says otherwise
	localparam int DEFAULT_DEPTH = 4;

endpackage

`default_nettype wire

//--- verilog/credit_fifo.sv
// Credit link receive buffer, circular storage that returns a credit per pop
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
	parameter type item_t = logic [7:0],
	parameter int DEPTH = credit_link_pkg::DEFAULT_DEPTH
) (
	input  logic  sys_clk,
	input  logic  resetn,
	input  logic  push,
	input  item_t push_data,
	input  logic  pop,
	output item_t pop_data,
	output logic  not_empty,
	output logic  credit
);
	import credit_link_pkg::*;

	// At least one pointer bit even for a single slot
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	item_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	credit_t count;
	logic do_pop;

	// Wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Pop of an empty buffer is ignored
	assign do_pop    = pop && not_empty;
	assign not_empty = (count != '0);
	// Head item visible without a cycle of delay
	assign pop_data  = mem[rd_ptr];

	// Storage
	always_ff @(posedge sys_clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers, fill count and the credit return
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// One cycle pulse per freed slot
			credit <= do_pop;
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/angle_stage.sv
// Angle stage, turns stick angle targets and measured angles into rate targets
`timescale 1ns/1ps
`default_nettype none

module angle_stage #(
	parameter int DEPTH_OUT = credit_link_pkg::DEFAULT_DEPTH,
	parameter int ANGLE_SHIFT = 1
) (
	input  logic                            sys_clk,
	input  logic                            resetn,
	input  logic                            in_valid,
	input  flight_types_pkg::flight_sample_t in_data,
	output logic                            in_pop,
	output logic                            out_valid,
	output flight_types_pkg::rate_target_t  out_data,
	input  logic                            out_credit
);
	import flight_types_pkg::*;
	import credit_link_pkg::*;

	credit_t credits;
	// One bit wider than an angle so the error never wraps
	logic signed [ANGLE_W:0] roll_err;
	logic signed [ANGLE_W:0] pitch_err;

	// Stick offset from center as a signed angle
	function automatic angle_t centered(input stick_t stick);
		return angle_t'($signed({1'b0, stick}) - STICK_CENTER);
	endfunction

	// Take an item only with room downstream
	assign in_pop = in_valid && (credits != '0);

	// Target minus measured angle
	assign roll_err  = centered(in_data.roll_stick) - in_data.roll_angle;
	assign pitch_err = centered(in_data.pitch_stick) - in_data.pitch_angle;

	// Result register
	always_ff @(posedge sys_clk) begin
		if (in_pop) begin
			out_data.throttle     <= in_data.throttle;
			out_data.roll_target  <= angle_t'(roll_err >>> ANGLE_SHIFT);
			out_data.pitch_target <= angle_t'(pitch_err >>> ANGLE_SHIFT);
			// Yaw flown in rate mode, stick is the rate
			out_data.yaw_target   <= centered(in_data.yaw_stick);
			out_data.roll_rate    <= in_data.roll_rate;
			out_data.pitch_rate   <= in_data.pitch_rate;
			out_data.yaw_rate     <= in_data.yaw_rate;
		end
	end

	// Valid flag and downstream credit count
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			out_valid <= 1'b0;
			credits   <= credit_t'(DEPTH_OUT);
		end else begin
			out_valid <= in_pop;
			// A pop spends the credit of the item it sends
			case ({in_pop, out_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/rate_stage.sv
// Rate stage, proportional rate correction per axis with saturation
`timescale 1ns/1ps
`default_nettype none

module rate_stage #(
	parameter int DEPTH_OUT = credit_link_pkg::DEFAULT_DEPTH,
	parameter int RATE_GAIN = 8
) (
	input  logic                           sys_clk,
	input  logic                           resetn,
	input  logic                           in_valid,
	input  flight_types_pkg::rate_target_t in_data,
	output logic                           in_pop,
	output logic                           out_valid,
	output flight_types_pkg::correction_t  out_data,
	input  logic                           out_credit
);
	import flight_types_pkg::*;
	import credit_link_pkg::*;

	credit_t credits;

	// Gain is in sixteenths, result held to the correction limit
	function automatic angle_t correct(input angle_t target, input angle_t rate);
		logic signed [31:0] err;
		logic signed [31:0] scaled;
		err = target - rate;
		scaled = (err * RATE_GAIN) >>> 4;
		if (scaled > CORR_LIMIT) begin
			return angle_t'(CORR_LIMIT);
		end
		if (scaled < -CORR_LIMIT) begin
			return angle_t'(-CORR_LIMIT);
		end
		return angle_t'(scaled);
	endfunction

	// Stall when the mix buffer has no free slot
	assign in_pop = in_valid && (credits != '0);

	// Result register
	always_ff @(posedge sys_clk) begin
		if (in_pop) begin
			out_data.throttle   <= in_data.throttle;
			out_data.roll_corr  <= correct(in_data.roll_target, in_data.roll_rate);
			out_data.pitch_corr <= correct(in_data.pitch_target, in_data.pitch_rate);
			out_data.yaw_corr   <= correct(in_data.yaw_target, in_data.yaw_rate);
		end
	end

	// Valid flag and credits toward the mixer
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			out_valid <= 1'b0;
			credits   <= credit_t'(DEPTH_OUT);
		end else begin
			out_valid <= in_pop;
			case ({in_pop, out_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/motor_mix_stage.sv
// Motor mixer, X-quad mix of throttle and corrections clamped to the ESC range
`timescale 1ns/1ps
`default_nettype none

module motor_mix_stage #(
	parameter int DEPTH_OUT = credit_link_pkg::DEFAULT_DEPTH
) (
	input  logic                           sys_clk,
	input  logic                           resetn,
	input  logic                           in_valid,
	input  flight_types_pkg::correction_t  in_data,
	output logic                           in_pop,
	output logic                           out_valid,
	output flight_types_pkg::motor_rates_t out_data,
	input  logic                           out_credit
);
	import flight_types_pkg::*;
	import credit_link_pkg::*;

	credit_t credits;
	int thr;
	int roll;
	int pitch;
	int yaw;
	logic disarm;

	// Hold a mix sum inside 0..MOTOR_MAX
	function automatic motor_t clamp_motor(input int sum);
		if (sum < 0) begin
			return '0;
		end
		if (sum > MOTOR_MAX) begin
			return motor_t'(MOTOR_MAX);
		end
		return motor_t'(sum);
	endfunction

	// Credits here come from the external consumer
	assign in_pop = in_valid && (credits != '0);

	// Throttle is unsigned, corrections sign extend
	assign thr    = int'(in_data.throttle);
	assign roll   = int'(in_data.roll_corr);
	assign pitch  = int'(in_data.pitch_corr);
	assign yaw    = int'(in_data.yaw_corr);
	assign disarm = (in_data.throttle < ARM_THRESHOLD);

	// Motor register
	always_ff @(posedge sys_clk) begin
		if (in_pop) begin
			if (disarm) begin
				out_data <= '0;
			end else begin
				// Front pair on pitch, diagonals share yaw sign
				out_data.motor_1 <= clamp_motor(thr + pitch + roll - yaw);
				out_data.motor_2 <= clamp_motor(thr + pitch - roll + yaw);
				out_data.motor_3 <= clamp_motor(thr - pitch - roll - yaw);
				out_data.motor_4 <= clamp_motor(thr - pitch + roll + yaw);
			end
		end
	end

	// Valid flag and output credit count
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			out_valid <= 1'b0;
			credits   <= credit_t'(DEPTH_OUT);
		end else begin
			out_valid <= in_pop;
			case ({in_pop, out_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/flight_pipeline.sv
// Flight control core, angle, rate and mix stages joined by credit links
`timescale 1ns/1ps
`default_nettype none

module flight_pipeline #(
	parameter int IN_DEPTH    = credit_link_pkg::DEFAULT_DEPTH,
	parameter int MID_DEPTH   = credit_link_pkg::DEFAULT_DEPTH,
	parameter int OUT_CREDITS = credit_link_pkg::DEFAULT_DEPTH,
	parameter int ANGLE_SHIFT = 1,
	parameter int RATE_GAIN   = 8
) (
	input  logic                            sys_clk,
	input  logic                            resetn,
	input  logic                            sample_valid,
	input  flight_types_pkg::flight_sample_t sample,
	output logic                            sample_credit,
	output logic                            motor_valid,
	output flight_types_pkg::motor_rates_t  motor,
	input  logic                            motor_credit
);
	import flight_types_pkg::*;

	// Input buffer to angle stage
	flight_sample_t angle_in;
	logic angle_in_valid;
	logic angle_pop;
	// Angle stage to rate buffer
	rate_target_t rt_data;
	logic rt_valid;
	logic rt_credit;
	rate_target_t rate_in;
	logic rate_in_valid;
	logic rate_pop;
	// Rate stage to mix buffer
	correction_t corr_data;
	logic corr_valid;
	logic corr_credit;
	correction_t mix_in;
	logic mix_in_valid;
	logic mix_pop;

	// Source holds IN_DEPTH credits for this one
	credit_fifo #(.item_t(flight_sample_t), .DEPTH(IN_DEPTH)) in_buf (
		.sys_clk(sys_clk), .resetn(resetn),
		.push(sample_valid), .push_data(sample),
		.pop(angle_pop), .pop_data(angle_in),
		.not_empty(angle_in_valid), .credit(sample_credit));

	angle_stage #(.DEPTH_OUT(MID_DEPTH), .ANGLE_SHIFT(ANGLE_SHIFT)) angle (
		.sys_clk(sys_clk), .resetn(resetn),
		.in_valid(angle_in_valid), .in_data(angle_in), .in_pop(angle_pop),
		.out_valid(rt_valid), .out_data(rt_data), .out_credit(rt_credit));

	credit_fifo #(.item_t(rate_target_t), .DEPTH(MID_DEPTH)) rate_buf (
		.sys_clk(sys_clk), .resetn(resetn),
		.push(rt_valid), .push_data(rt_data),
		.pop(rate_pop), .pop_data(rate_in),
		.not_empty(rate_in_valid), .credit(rt_credit));

	rate_stage #(.DEPTH_OUT(MID_DEPTH), .RATE_GAIN(RATE_GAIN)) rate (
		.sys_clk(sys_clk), .resetn(resetn),
		.in_valid(rate_in_valid), .in_data(rate_in), .in_pop(rate_pop),
		.out_valid(corr_valid), .out_data(corr_data), .out_credit(corr_credit));

	credit_fifo #(.item_t(correction_t), .DEPTH(MID_DEPTH)) mix_buf (
		.sys_clk(sys_clk), .resetn(resetn),
		.push(corr_valid), .push_data(corr_data),
		.pop(mix_pop), .pop_data(mix_in),
		.not_empty(mix_in_valid), .credit(corr_credit));

	// Consumer side credits sized by OUT_CREDITS
	motor_mix_stage #(.DEPTH_OUT(OUT_CREDITS)) mix (
		.sys_clk(sys_clk), .resetn(resetn),
		.in_valid(mix_in_valid), .in_data(mix_in), .in_pop(mix_pop),
		.out_valid(motor_valid), .out_data(motor), .out_credit(motor_credit));

endmodule

`default_nettype wire

//--- bench/flight_pipeline_assert.sv
// Flight pipeline checks on credit discipline, reset state and motor range
`timescale 1ns/1ps
`default_nettype none

module flight_pipeline_assert #(
	parameter int IN_DEPTH    = credit_link_pkg::DEFAULT_DEPTH,
	parameter int OUT_CREDITS = credit_link_pkg::DEFAULT_DEPTH
) (
	input logic                           sys_clk,
	input logic                           resetn,
	input logic                           sample_valid,
	input logic                           sample_credit,
	input logic                           motor_valid,
	input flight_types_pkg::motor_rates_t motor,
	input logic                           motor_credit
);
	import flight_types_pkg::*;

	// Items inside the pipeline not yet credited back to the source
	int in_pending;
	// Outputs the consumer has not yet credited
	int out_pending;
	// Failures so far, the testbench adds these to its own
	int fail_count = 0;

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			in_pending  <= 0;
			out_pending <= 0;
		end else begin
			in_pending  <= in_pending + int'(sample_valid) - int'(sample_credit);
			out_pending <= out_pending + int'(motor_valid) - int'(motor_credit);
		end
	end

	// Both links idle right out of reset
	reset_idle: assert property (@(posedge sys_clk)
		!resetn |=> (!sample_credit && !motor_valid))
		else begin
			$error("sample_credit or motor_valid high after reset");
			fail_count++;
		end

	// Mixer never runs past the consumer's credits
	out_credit_bound: assert property (@(posedge sys_clk) disable iff (!resetn)
		out_pending <= OUT_CREDITS)
		else begin
			$error("more than OUT_CREDITS motor outputs outstanding");
			fail_count++;
		end

	// Input buffer never overfilled nor credited past empty
	in_credit_bound: assert property (@(posedge sys_clk) disable iff (!resetn)
		in_pending >= 0 && in_pending <= IN_DEPTH)
		else begin
			$error("input items outstanding outside 0 to IN_DEPTH");
			fail_count++;
		end

	// ESC range on every motor
	motor_range: assert property (@(posedge sys_clk) disable iff (!resetn)
		motor_valid |-> (motor.motor_1 <= MOTOR_MAX && motor.motor_2 <= MOTOR_MAX &&
			motor.motor_3 <= MOTOR_MAX && motor.motor_4 <= MOTOR_MAX))
		else begin
			$error("motor rate above MOTOR_MAX");
			fail_count++;
		end

endmodule

bind flight_pipeline flight_pipeline_assert #(
	.IN_DEPTH(IN_DEPTH),
	.OUT_CREDITS(OUT_CREDITS)
) credit_checks (
	.sys_clk(sys_clk),
	.resetn(resetn),
	.sample_valid(sample_valid),
	.sample_credit(sample_credit),
	.motor_valid(motor_valid),
	.motor(motor),
	.motor_credit(motor_credit)
);

`default_nettype wire

//--- bench/flight_pipeline_tb.sv
// Flight pipeline testbench, directed and random samples against a reference model
`timescale 1ns/1ps
`default_nettype none

module flight_pipeline_tb;
	import flight_types_pkg::*;
	import credit_link_pkg::*;

	localparam int IN_DEPTH    = DEFAULT_DEPTH;
	localparam int MID_DEPTH   = DEFAULT_DEPTH;
	localparam int OUT_CREDITS = DEFAULT_DEPTH;
	localparam int ANGLE_SHIFT = 1;
	localparam int RATE_GAIN   = 8;
	// Cycles any single wait may take
	localparam int WAIT_LIMIT  = 3000;

	logic sys_clk;
	logic resetn;
	logic sample_valid;
	flight_sample_t sample;
	logic sample_credit;
	logic motor_valid;
	motor_rates_t motor;
	logic motor_credit;

	// Model results in send order
	motor_rates_t expected[$];
	logic [31:0] lfsr_state;
	int in_credits;
	// Outputs seen but not yet credited back
	int owed;
	// 0 withhold, 1 return at once, 2 return on random cycles
	int credit_mode;
	int motor_count;
	int errors;
	int test_errors;
	int tests_passed;
	int tests_failed;

	flight_pipeline #(
		.IN_DEPTH(IN_DEPTH), .MID_DEPTH(MID_DEPTH), .OUT_CREDITS(OUT_CREDITS),
		.ANGLE_SHIFT(ANGLE_SHIFT), .RATE_GAIN(RATE_GAIN)
	) uut (
		.sys_clk(sys_clk), .resetn(resetn),
		.sample_valid(sample_valid), .sample(sample), .sample_credit(sample_credit),
		.motor_valid(motor_valid), .motor(motor), .motor_credit(motor_credit));

	always #4 sys_clk = ~sys_clk;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Signed value spread evenly over the given width
	function automatic angle_t random_angle(input int bits);
		return angle_t'(int'(random_bits(bits)) - (1 << (bits - 1)));
	endfunction

	function automatic int limit(input int v, input int lo, input int hi);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	// Angle law, P rate law and X mix applied to one sample
	function automatic motor_rates_t model(input flight_sample_t s);
		int roll_rt;
		int pitch_rt;
		int yaw_rt;
		int rc;
		int pc;
		int yc;
		int thr;
		motor_rates_t m;
		roll_rt  = ((int'(s.roll_stick) - STICK_CENTER) - int'(s.roll_angle)) >>> ANGLE_SHIFT;
		pitch_rt = ((int'(s.pitch_stick) - STICK_CENTER) - int'(s.pitch_angle)) >>> ANGLE_SHIFT;
		yaw_rt   = int'(s.yaw_stick) - STICK_CENTER;
		rc = limit(((roll_rt - int'(s.roll_rate)) * RATE_GAIN) >>> 4, -CORR_LIMIT, CORR_LIMIT);
		pc = limit(((pitch_rt - int'(s.pitch_rate)) * RATE_GAIN) >>> 4, -CORR_LIMIT, CORR_LIMIT);
		yc = limit(((yaw_rt - int'(s.yaw_rate)) * RATE_GAIN) >>> 4, -CORR_LIMIT, CORR_LIMIT);
		thr = int'(s.throttle);
		m = '0;
		if (thr >= ARM_THRESHOLD) begin
			m.motor_1 = motor_t'(limit(thr + pc + rc - yc, 0, MOTOR_MAX));
			m.motor_2 = motor_t'(limit(thr + pc - rc + yc, 0, MOTOR_MAX));
			m.motor_3 = motor_t'(limit(thr - pc - rc - yc, 0, MOTOR_MAX));
			m.motor_4 = motor_t'(limit(thr - pc + rc + yc, 0, MOTOR_MAX));
		end
		return m;
	endfunction

	// Centered sticks, level and still
	function automatic flight_sample_t level(input int thr);
		flight_sample_t s;
		s = '0;
		s.throttle    = stick_t'(thr);
		s.roll_stick  = stick_t'(STICK_CENTER);
		s.pitch_stick = stick_t'(STICK_CENTER);
		s.yaw_stick   = stick_t'(STICK_CENTER);
		return s;
	endfunction

	// One clock, outputs sampled after the edge, then inputs back to idle
	task automatic tick();
		@(posedge sys_clk);
		#1;
		sample_valid = 1'b0;
		motor_credit = 1'b0;
		if (sample_credit) begin
			in_credits++;
		end
		if (motor_valid) begin
			motor_count++;
			owed++;
			if (expected.size() == 0) begin
				$display("Motor output at %0t ns with no sample outstanding", $time);
				errors++;
			end else begin
				assert (motor == expected[0]) else begin
					$display("Error: %0t ns motor expected %h actual %h", $time, expected[0], motor);
					errors++;
				end
				void'(expected.pop_front());
			end
		end
		if (owed > 0 && (credit_mode == 1 || (credit_mode == 2 && random_bits(1) == 1))) begin
			motor_credit = 1'b1;
			owed--;
		end
	endtask

	// Waits for an input credit, then pushes one sample
	task automatic send(input flight_sample_t s);
		int waited;
		waited = 0;
		while (in_credits == 0 && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (in_credits == 0) begin
			$display("Timed out at %0t ns waiting for an input credit", $time);
			errors++;
		end else begin
			sample = s;
			sample_valid = 1'b1;
			in_credits--;
			expected.push_back(model(s));
			tick();
		end
	endtask

	// Runs until every expected result has come out
	task automatic drain();
		int waited;
		waited = 0;
		while (expected.size() != 0 && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (expected.size() != 0) begin
			$display("Timed out with %0d motor results never delivered", expected.size());
			errors++;
		end
	endtask

	task automatic start_test();
		test_errors = errors;
	endtask

	task automatic end_test(input string name);
		if (errors == test_errors) begin
			tests_passed++;
			$display("Test %s passed", name);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, errors - test_errors);
		end
	endtask

	initial begin
		flight_sample_t s;
		int waited;
		sys_clk = 1'b0;
		resetn = 1'b0;
		sample_valid = 1'b0;
		sample = '0;
		motor_credit = 1'b0;
		lfsr_state = 32'h4a4a;
		in_credits = IN_DEPTH;
		owed = 0;
		credit_mode = 1;
		motor_count = 0;
		errors = 0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (2) @(posedge sys_clk);
		#1;
		resetn = 1'b1;

		start_test();
		send(level(100));
		drain();
		end_test("level hover");

		// One axis at a time
		start_test();
		s = level(120);
		s.roll_stick = 8'd160;
		send(s);
		s = level(120);
		s.pitch_angle = 16'sd40;
		send(s);
		s = level(120);
		s.yaw_stick = 8'd100;
		s.yaw_rate = -16'sd10;
		send(s);
		s = level(120);
		s.roll_rate = 16'sd12;
		send(s);
		drain();
		end_test("axis responses");

		start_test();
		send(level(9));
		send(level(10));
		s = level(9);
		s.roll_stick = 8'd200;
		send(s);
		drain();
		end_test("disarm");

		// Corrections pinned at the limit, mix pinned at both ESC ends
		start_test();
		s = level(255);
		s.roll_angle = -16'sd20000;
		send(s);
		s = level(20);
		s.pitch_angle = 16'sd20000;
		send(s);
		s = level(128);
		s.yaw_stick = 8'd255;
		s.roll_angle = 16'sd30000;
		send(s);
		drain();
		end_test("saturation");

		// Fill every buffer with the consumer holding its credits
		start_test();
		credit_mode = 0;
		motor_count = 0;
		for (int i = 0; i < IN_DEPTH + 2 * MID_DEPTH + OUT_CREDITS; i++) begin
			s = level(50 + i);
			s.roll_stick = stick_t'(128 + i);
			send(s);
		end
		waited = 0;
		while (motor_count < OUT_CREDITS && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (motor_count < OUT_CREDITS) begin
			$display("Timed out waiting for the first OUT_CREDITS motor outputs");
			errors++;
		end
		// Room for a stray output or input credit to appear
		for (int i = 0; i < 4 * IN_DEPTH; i++) begin
			tick();
		end
		assert (motor_count == OUT_CREDITS) else begin
			$display("Error: %0t ns motor_valid count expected %0d actual %0d",
				$time, OUT_CREDITS, motor_count);
			errors++;
		end
		assert (in_credits == 0) else begin
			$display("Error: %0t ns sample_credit count expected 0 actual %0d", $time, in_credits);
			errors++;
		end
		credit_mode = 1;
		drain();
		end_test("back-pressure");

		start_test();
		credit_mode = 2;
		for (int n = 0; n < 200; n++) begin
			s.throttle    = stick_t'(random_bits(8));
			s.roll_stick  = stick_t'(random_bits(8));
			s.pitch_stick = stick_t'(random_bits(8));
			s.yaw_stick   = stick_t'(random_bits(8));
			s.roll_angle  = random_angle(10);
			s.pitch_angle = random_angle(10);
			s.yaw_angle   = random_angle(10);
			s.roll_rate   = random_angle(8);
			s.pitch_rate  = random_angle(8);
			s.yaw_rate    = random_angle(8);
			if (random_bits(1) == 1) begin
				tick();
			end
			send(s);
		end
		drain();
		end_test("random stream");

		errors += uut.credit_checks.fail_count;
		$display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
			tests_passed, tests_failed, uut.credit_checks.fail_count);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
verilog/flight_types_pkg.sv
verilog/credit_link_pkg.sv
verilog/credit_fifo.sv
verilog/angle_stage.sv
verilog/rate_stage.sv
verilog/motor_mix_stage.sv
verilog/flight_pipeline.sv
bench/flight_pipeline_assert.sv
bench/flight_pipeline_tb.sv
